// ==== design/clk_ctrl_defines.svh ====
// ==================================================
// clock control constants
// source count, fail window, register map and ID
// ==================================================
`ifndef CLK_CTRL_DEFINES_SVH
`define CLK_CTRL_DEFINES_SVH

// source 0 is the always-on internal oscillator
`define CLK_NUM      4
`define CLK_SEL_W    $clog2(`CLK_NUM)
// clk cycles per fail-check window
`define FAIL_WINDOW  64

// register byte offsets
`define REG_SEL      32'h0000_0000
`define REG_STATUS   32'h0000_0004
`define REG_ID       32'h0000_0008
`define CLK_CTRL_ID  32'hc1c0_0001

`endif

// ==== design/clk_pkg.sv ====
// ==================================================
// clock-side types
// source vector, select index and status word
// ==================================================
`default_nettype none

`include "clk_ctrl_defines.svh"

package clk_pkg;

  // one bit per source clock
  typedef logic [`CLK_NUM-1:0] clk_vec_t;

  // index of a source clock
  typedef logic [`CLK_SEL_W-1:0] clk_sel_t;

  // STATUS register contents, active in the upper half
  typedef struct packed {
    clk_vec_t active;
    clk_vec_t fail;
  } clk_status_t;

endpackage

`default_nettype wire

// ==== design/axil_pkg.sv ====
// ==================================================
// AXI4-Lite channel bundles
// master request, slave response, response codes
// ==================================================
`default_nettype none

package axil_pkg;

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // response codes
  localparam logic [1:0] AXIL_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_SLVERR = 2'b10;

  // master to slave
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== design/cdc_sync.sv ====
// ==================================================
// two-flop synchronizer
// brings a slow level-type value into clk domain
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module cdc_sync #(
  parameter type T = logic
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire T     d,
  output T          q
);

  // first stage may go metastable
  T meta;

  always_ff @(posedge clk) begin
    if (rst) begin
      meta <= '0;
      q    <= '0;
    end else begin
      meta <= d;
      q    <= meta;
    end
  end

endmodule

`default_nettype wire

// ==== design/clk_fail_monitor.sv ====
// ==================================================
// clock fail monitor
// counts edges of each monitored source per window
// of clk cycles, sticky fail bit on an empty window
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "clk_ctrl_defines.svh"

module clk_fail_monitor import clk_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire clk_vec_t src_clk,
  output clk_vec_t      clk_fail
);

  localparam int N     = `CLK_NUM;
  localparam int CNT_W = $clog2(`FAIL_WINDOW);

  logic [CNT_W-1:0] win_cnt;
  logic             win_end;
  // one sticky bit per monitored source
  logic             fail_arr [1:N-1];

  // ==================================================
  // window timer
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      win_cnt <= '0;
    end else if (win_end) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  assign win_end = (win_cnt == CNT_W'(`FAIL_WINDOW - 1));

  // ==================================================
  // per-source edge check
  // ==================================================
  for (genvar n = 1; n < N; n++) begin : g_mon
    logic tog;
    logic tog_s;
    logic tog_d;
    logic seen;
    logic edge_det;

    // source divides itself by two
    // level carries no meaning, only its changes
    always_ff @(posedge src_clk[n]) begin
      if (rst) begin
        tog <= 1'b0;
      end else begin
        tog <= ~tog;
      end
    end

    cdc_sync #(.T(logic)) u_tog_sync (
      .clk (clk),
      .rst (rst),
      .d   (tog),
      .q   (tog_s)
    );

    // any change of the synced toggle is one edge
    assign edge_det = tog_s ^ tog_d;

    always_ff @(posedge clk) begin
      if (rst) begin
        tog_d       <= 1'b0;
        seen        <= 1'b0;
        fail_arr[n] <= 1'b0;
      end else begin
        tog_d <= tog_s;
        if (win_end) begin
          // window closes, restart edge tracking
          seen <= edge_det;
          if (!seen && !edge_det) begin
            fail_arr[n] <= 1'b1;
          end
        end else if (edge_det) begin
          seen <= 1'b1;
        end
      end
    end
  end

  // internal oscillator is never flagged
  always_comb begin
    clk_fail    = '0;
    for (int i = 1; i < N; i++) begin
      clk_fail[i] = fail_arr[i];
    end
  end

endmodule

`default_nettype wire

// ==== design/sys_clk_switch.sv ====
// ==================================================
// glitch-free N-way clock switch
// select may change at any time, failed sources
// fall back to source 0, scan clock overrides all
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "clk_ctrl_defines.svh"

module sys_clk_switch import clk_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire clk_vec_t src_clk,
  input  wire clk_sel_t sel_req,
  input  wire clk_vec_t clk_fail,
  input  wire logic     scan_mode,
  input  wire logic     test_clk,
  output clk_vec_t      clk_active,
  output logic          o_clk
);

  localparam int N = `CLK_NUM;
  localparam clk_vec_t SRC0 = clk_vec_t'(1);

  clk_sel_t sel_eff;
  clk_vec_t sel_onehot;
  clk_vec_t onehot_q;
  // qualified select, per source
  clk_vec_t clk_sel;
  // synced reset release, per source
  clk_vec_t dom_run;
  // second-stage select, per source
  clk_vec_t stage_q;
  clk_vec_t clk_en;
  clk_vec_t clk_gated;
  logic     raw_clk;

  // ==================================================
  // effective selection, clk domain
  // ==================================================
  always_comb begin
    // failed request falls back to the oscillator
    sel_eff             = clk_fail[sel_req] ? '0 : sel_req;
    sel_onehot          = '0;
    sel_onehot[sel_eff] = 1'b1;
  end

  // registered so the domains see a clean level
  always_ff @(posedge clk) begin
    if (rst) begin
      onehot_q <= SRC0;
    end else begin
      onehot_q <= sel_onehot;
    end
  end

  // ==================================================
  // per-domain select flops
  // ==================================================
  for (genvar n = 0; n < N; n++) begin : g_dom
    localparam clk_vec_t OTHERS = ~(SRC0 << n);
    logic src_clk_n;
    logic dom_rst;
    logic stage_raw;

    // wait until every other source is off
    assign clk_sel[n] = onehot_q[n] && !(|(clk_en & OTHERS));

    // domain reset, released on the source's own clock
    cdc_sync #(.T(logic)) u_rst_sync (
      .clk (src_clk[n]),
      .rst (rst),
      .d   (1'b1),
      .q   (dom_run[n])
    );

    // fail clears the flops if the source ever runs again
    assign dom_rst   = ~dom_run[n] | clk_fail[n];
    // falling edge, enable moves while the source is low
    assign src_clk_n = ~src_clk[n];

    if (n == 0) begin : g_src0
      // inverted so the oscillator is on during reset
      cdc_sync #(.T(logic)) u_sel_sync (
        .clk (src_clk_n),
        .rst (dom_rst),
        .d   (~clk_sel[n]),
        .q   (stage_raw)
      );
      assign stage_q[n] = ~stage_raw;
    end else begin : g_srcn
      cdc_sync #(.T(logic)) u_sel_sync (
        .clk (src_clk_n),
        .rst (dom_rst),
        .d   (clk_sel[n]),
        .q   (stage_raw)
      );
      assign stage_q[n] = stage_raw;
    end
  end

  // stopped source cannot clock its flops clear
  assign clk_en     = stage_q & ~clk_fail;
  assign clk_active = clk_en;

  // ==================================================
  // output gating and scan mux
  // ==================================================
  assign clk_gated = src_clk & clk_en;
  assign raw_clk   = |clk_gated;
  assign o_clk     = scan_mode ? test_clk : raw_clk;

endmodule

`default_nettype wire

// ==== design/clk_ctrl_regs.sv ====
// ==================================================
// clock control register slave
// AXI4-Lite, holds SEL and reads back STATUS and ID
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "clk_ctrl_defines.svh"

module clk_ctrl_regs import clk_pkg::*, axil_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire axil_req_t axil_req,
  output axil_rsp_t      axil_rsp,
  input  wire clk_vec_t  clk_fail,
  input  wire clk_vec_t  clk_active,
  output clk_sel_t       sel_req
);

  // handshake control
  logic        aw_rdy;
  logic        ar_rdy;
  logic        bvalid;
  logic        rvalid;
  logic        wr_fire;
  logic        rd_fire;
  // response payload
  logic [1:0]  bresp;
  logic [1:0]  rresp;
  axil_data_t  rdata;
  // register state and read mux
  clk_sel_t    sel_q;
  clk_vec_t    active_s;
  clk_status_t status;
  axil_data_t  rd_data;
  logic        rd_err;
  logic        wr_known;

  // each active bit comes from its own source domain
  cdc_sync #(.T(clk_vec_t)) u_active_sync (
    .clk (clk),
    .rst (rst),
    .d   (clk_active),
    .q   (active_s)
  );

  assign status.active = active_s;
  assign status.fail   = clk_fail;

  // ==================================================
  // address decode
  // ==================================================
  assign wr_known = (axil_req.awaddr == `REG_SEL)    ||
                    (axil_req.awaddr == `REG_STATUS) ||
                    (axil_req.awaddr == `REG_ID);

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      `REG_SEL:    rd_data = axil_data_t'(sel_q);
      `REG_STATUS: rd_data = axil_data_t'(status);
      `REG_ID:     rd_data = `CLK_CTRL_ID;
      default:     rd_err  = 1'b1;
    endcase
  end

  // ready high and both valids seen
  assign wr_fire = aw_rdy && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = ar_rdy && axil_req.arvalid;

  // ==================================================
  // write channel
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_rdy <= 1'b0;
      bvalid <= 1'b0;
      sel_q  <= '0;
    end else begin
      // one-cycle ready, blocked by a pending response
      aw_rdy <= axil_req.awvalid && axil_req.wvalid && !bvalid && !aw_rdy;
      if (wr_fire) begin
        bvalid <= 1'b1;
        // SEL only updates with byte lane 0 enabled
        if (axil_req.awaddr == `REG_SEL && axil_req.wstrb[0]) begin
          sel_q <= axil_req.wdata[`CLK_SEL_W-1:0];
        end
      end else if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_known ? AXIL_OKAY : AXIL_SLVERR;
    end
  end

  // ==================================================
  // read channel
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ar_rdy <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      ar_rdy <= axil_req.arvalid && !rvalid && !ar_rdy;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // data held steady until rready
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_data;
      rresp <= rd_err ? AXIL_SLVERR : AXIL_OKAY;
    end
  end

  // response bundle
  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = aw_rdy;
    axil_rsp.wready  = aw_rdy;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = ar_rdy;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

  assign sel_req = sel_q;

endmodule

`default_nettype wire

// ==== design/clk_ctrl_top.sv ====
// ==================================================
// clock control top
// register slave, fail monitor and clock switch
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_top import clk_pkg::*, axil_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire clk_vec_t  src_clk,
  input  wire logic      scan_mode,
  input  wire logic      test_clk,
  input  wire axil_req_t axil_req,
  output axil_rsp_t      axil_rsp,
  output logic           o_clk
);

  // clk domain
  clk_sel_t sel_req;
  clk_vec_t clk_fail;
  // one bit per source domain
  clk_vec_t clk_active;

  clk_ctrl_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .clk_fail   (clk_fail),
    .clk_active (clk_active),
    .sel_req    (sel_req)
  );

  clk_fail_monitor u_monitor (
    .clk      (clk),
    .rst      (rst),
    .src_clk  (src_clk),
    .clk_fail (clk_fail)
  );

  sys_clk_switch u_switch (
    .clk        (clk),
    .rst        (rst),
    .src_clk    (src_clk),
    .sel_req    (sel_req),
    .clk_fail   (clk_fail),
    .scan_mode  (scan_mode),
    .test_clk   (test_clk),
    .clk_active (clk_active),
    .o_clk      (o_clk)
  );

endmodule

`default_nettype wire

// ==== sim/clk_ctrl_checker.sv ====
// ==================================================
// clock control checker
// measures o_clk pulses and periods, and compares
// register values handed over by the testbench
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_checker (
  input  wire logic o_clk,
  input  wire logic pulse_en,
  input  wire logic period_en,
  input  var  int   exp_period_ps
);

  // half the 7 ns oscillator, small margin for rounding
  localparam realtime MIN_PULSE = 3.49;

  int      value_errs   = 0;
  int      period_errs  = 0;
  int      pulse_errs   = 0;
  int      other_errs   = 0;
  int      period_count = 0;
  string   step_name    = "none";
  realtime t_rise;
  realtime t_fall;
  bit      have_rise    = 1'b0;
  bit      have_fall    = 1'b0;
  bit      armed        = 1'b0;

  function automatic void set_step(input string name);
    step_name = name;
  endfunction

  function automatic void compare_value(input string name, input logic [31:0] exp_v,
                                        input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      value_errs++;
    end
  endfunction

  function automatic void report_failure(input string msg);
    $display("ERROR %s: %s", step_name, msg);
    other_errs++;
  endfunction

  // ==================================================
  // rising edge: low pulse and period
  // ==================================================
  always @(posedge o_clk) begin
    int meas_ps;
    if (have_fall && pulse_en && ($realtime - t_fall) < MIN_PULSE) begin
      $display("ERROR %s: o_clk low pulse of %0t too short", step_name, $realtime - t_fall);
      pulse_errs++;
    end
    if (have_rise && armed && period_en) begin
      meas_ps = int'(($realtime - t_rise) * 1000.0);
      period_count++;
      // allow a few ps of rounding
      if (meas_ps > exp_period_ps + 5 || meas_ps < exp_period_ps - 5) begin
        $display("MISMATCH %s period expected %0d ps actual %0d ps",
                 step_name, exp_period_ps, meas_ps);
        period_errs++;
      end
    end
    armed     = period_en;
    t_rise    = $realtime;
    have_rise = pulse_en;
  end

  // falling edge: high pulse
  always @(negedge o_clk) begin
    if (have_rise && pulse_en && ($realtime - t_rise) < MIN_PULSE) begin
      $display("ERROR %s: o_clk high pulse of %0t too short", step_name, $realtime - t_rise);
      pulse_errs++;
    end
    t_fall    = $realtime;
    have_fall = pulse_en;
  end

endmodule

`default_nettype wire

// ==== sim/clk_ctrl_props.sv ====
// ==================================================
// clock control assertions
// response hold rules and one-hot switch enables
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_props import clk_pkg::*; (
  input wire logic     clk,
  input wire logic     rst,
  input wire logic     smp_clk,
  input wire clk_vec_t en,
  input wire logic     bvalid,
  input wire logic     bready,
  input wire logic     rvalid,
  input wire logic     rready
);

  // responses stay up until taken
  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (bvalid && !bready) |=> bvalid) else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> rvalid) else $error("rvalid dropped before rready");

  // never two sources gated onto o_clk
  a_en_onehot: assert property (@(posedge smp_clk) disable iff (rst)
    $onehot0(en)) else $error("more than one clock enable high");

endmodule

bind sys_clk_switch clk_ctrl_props u_switch_props (
  .clk (clk), .rst (rst), .smp_clk (test_clk), .en (clk_en),
  .bvalid (1'b0), .bready (1'b1), .rvalid (1'b0), .rready (1'b1)
);

bind clk_ctrl_regs clk_ctrl_props u_regs_props (
  .clk (clk), .rst (rst), .smp_clk (clk), .en ('0),
  .bvalid (bvalid), .bready (axil_req.bready),
  .rvalid (rvalid), .rready (axil_req.rready)
);

`default_nettype wire

// ==== sim/clk_ctrl_tb.sv ====
// ==================================================
// clock control testbench
// source clocks, AXI4-Lite tasks, step table and
// watchdog around clk_ctrl_top
// ==================================================
`timescale 1ns/1ps
`default_nettype none

`include "clk_ctrl_defines.svh"

module clk_ctrl_tb import clk_pkg::*, axil_pkg::*; ();

  localparam int N_ROWS     = 10;
  localparam int N_ORDER    = 14;
  // clk cycles allowed per step
  localparam int STEP_LIMIT = 3000;
  // read latency on top of the two fail windows
  localparam int FAIL_LIMIT = 2 * `FAIL_WINDOW + 16;

  logic      clk = 1'b0, rst = 1'b1, scan_mode = 1'b0, test_clk = 1'b0;
  logic      s0 = 1'b0, s1 = 1'b0, s2 = 1'b0, s3 = 1'b0;
  clk_vec_t  src_clk, stop_mask = '0;
  axil_req_t req = '0;
  axil_rsp_t rsp;
  logic      o_clk;
  logic      pulse_en = 1'b0, period_en = 1'b0;
  int        exp_period_ps = 7000;
  int        cyc = 0;
  int        seed = 32'hba58;
  logic [1:0] cur_sel = '0;

  // step table
  string      t_name [N_ROWS];
  logic [1:0] t_sel [N_ROWS];
  clk_vec_t   t_stop [N_ROWS];
  logic       t_scan [N_ROWS];
  int         t_idx [N_ROWS];
  int         t_per [N_ROWS];
  int         order [N_ORDER];

  // ==================================================
  // clocks, DUT and checker
  // ==================================================
  always #5 clk = ~clk;
  always #9 test_clk = ~test_clk;
  always #3.5 if (!stop_mask[0]) s0 = ~s0;
  always #6.5 if (!stop_mask[1]) s1 = ~s1;
  always #11 if (!stop_mask[2]) s2 = ~s2;
  always #15.5 if (!stop_mask[3]) s3 = ~s3;
  assign src_clk = {s3, s2, s1, s0};
  always @(posedge clk) cyc <= cyc + 1;

  clk_ctrl_top dut_i (
    .clk (clk), .rst (rst), .src_clk (src_clk), .scan_mode (scan_mode),
    .test_clk (test_clk), .axil_req (req), .axil_rsp (rsp), .o_clk (o_clk)
  );

  clk_ctrl_checker chk_i (
    .o_clk (o_clk), .pulse_en (pulse_en), .period_en (period_en),
    .exp_period_ps (exp_period_ps)
  );

  task automatic set_row(input int i, input string name, input logic [1:0] sel,
                         input clk_vec_t stop, input logic scan, input int idx, input int per);
    t_name[i] = name;
    t_sel[i]  = sel;
    t_stop[i] = stop;
    t_scan[i] = scan;
    t_idx[i]  = idx;
    t_per[i]  = per;
  endtask

  // ==================================================
  // AXI4-Lite master tasks, driven on falling edges
  // ==================================================
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int n;
    @(negedge clk);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    req.bready  = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rsp.awready && n < 100);
    if (n >= 100) chk_i.report_failure("write address never accepted");
    // data channel is taken on the same cycle as the address
    if (rsp.wready !== rsp.awready) chk_i.report_failure("wready not raised with awready");
    @(negedge clk);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    n = 0;
    while (!rsp.bvalid && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (n >= 100) chk_i.report_failure("write response never arrived");
    resp       = rsp.bresp;
    req.bready = 1'b1;
    @(negedge clk);
    req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(negedge clk);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rsp.arready && n < 100);
    if (n >= 100) chk_i.report_failure("read address never accepted");
    @(negedge clk);
    req.arvalid = 1'b0;
    n = 0;
    while (!rsp.rvalid && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (n >= 100) chk_i.report_failure("read data never arrived");
    data       = rsp.rdata;
    resp       = rsp.rresp;
    req.rready = 1'b1;
    @(negedge clk);
    req.rready = 1'b0;
  endtask

  // ==================================================
  // one table row
  // ==================================================
  task automatic apply_step(input int i);
    logic [1:0]  resp;
    logic [31:0] data;
    clk_status_t st;
    clk_vec_t    exp_act;
    int          start, stop_cyc, checks;
    bit          done, fail_timed;
    exp_act = clk_vec_t'(1) << t_idx[i];
    chk_i.set_step(t_name[i]);
    // scan mux is not glitch-free, mute pulse checks around it
    if (scan_mode !== t_scan[i]) begin
      @(negedge clk);
      pulse_en  = 1'b0;
      scan_mode = t_scan[i];
      #60;
      @(negedge clk);
      pulse_en = 1'b1;
    end
    @(negedge clk);
    fail_timed = (t_stop[i] & ~stop_mask) != '0;
    stop_mask  = t_stop[i];
    stop_cyc   = cyc;
    axi_write(`REG_SEL, 32'(t_sel[i]), 4'hf, resp);
    chk_i.compare_value({t_name[i], " bresp"}, 32'(AXIL_OKAY), 32'(resp));
    cur_sel = t_sel[i];
    axi_read(`REG_SEL, data, resp);
    chk_i.compare_value({t_name[i], " SEL"}, 32'(t_sel[i]), data);
    start = cyc;
    done  = 1'b0;
    while (!done && cyc - start < STEP_LIMIT) begin
      axi_read(`REG_STATUS, data, resp);
      st = clk_status_t'(data[2*`CLK_NUM-1:0]);
      if (fail_timed && (st.fail & stop_mask) == stop_mask) begin
        fail_timed = 1'b0;
        if (cyc - stop_cyc > FAIL_LIMIT) chk_i.report_failure("fail bit set too late");
      end
      done = (st.active == exp_act) && (st.fail == stop_mask);
    end
    if (!done) chk_i.report_failure("STATUS never reached expected source");
    chk_i.compare_value({t_name[i], " active"}, 32'(exp_act), 32'(st.active));
    chk_i.compare_value({t_name[i], " fail"}, 32'(stop_mask), 32'(st.fail));
    // period window after the switch has settled
    repeat (10) @(negedge clk);
    checks        = chk_i.period_count;
    exp_period_ps = t_per[i];
    period_en     = 1'b1;
    repeat (40) @(negedge clk);
    period_en = 1'b0;
    if (chk_i.period_count == checks) chk_i.report_failure("no o_clk periods seen");
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    logic [1:0]  resp;
    logic [31:0] data;
    int          j, tmp;
    set_row(0, "reset_src0", 2'd0, 4'b0000, 1'b0, 0, 7000);
    set_row(1, "sel1", 2'd1, 4'b0000, 1'b0, 1, 13000);
    set_row(2, "sel2", 2'd2, 4'b0000, 1'b0, 2, 22000);
    set_row(3, "sel3", 2'd3, 4'b0000, 1'b0, 3, 31000);
    set_row(4, "back0", 2'd0, 4'b0000, 1'b0, 0, 7000);
    set_row(5, "scan", 2'd0, 4'b0000, 1'b1, 0, 18000);
    set_row(6, "sel3_again", 2'd3, 4'b0000, 1'b0, 3, 31000);
    set_row(7, "stop3", 2'd3, 4'b1000, 1'b0, 0, 7000);
    set_row(8, "req3_failed", 2'd3, 4'b1000, 1'b0, 0, 7000);
    // leaves source 3 so the next request for it is a fresh one
    set_row(9, "sel1_fail3", 2'd1, 4'b1000, 1'b0, 1, 13000);
    order = '{0, 1, 2, 3, 4, 1, 2, 3, 4, 5, 6, 7, 9, 8};
    // shuffle the repeated select rows
    for (int k = 7; k > 5; k--) begin
      j          = 5 + ($unsigned($random(seed)) % (k - 4));
      tmp        = order[k];
      order[k]   = order[j];
      order[j]   = tmp;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (20) @(negedge clk);
    pulse_en = 1'b1;
    chk_i.set_step("id");
    axi_read(`REG_ID, data, resp);
    chk_i.compare_value("id", `CLK_CTRL_ID, data);
    chk_i.compare_value("id rresp", 32'(AXIL_OKAY), 32'(resp));
    for (int k = 0; k < N_ORDER; k++) apply_step(order[k]);
    // byte lane 0 clear leaves SEL alone
    chk_i.set_step("wstrb_clear");
    axi_write(`REG_SEL, 32'(cur_sel ^ 2'd1), 4'b1110, resp);
    axi_read(`REG_SEL, data, resp);
    chk_i.compare_value("wstrb_clear SEL", 32'(cur_sel), data);
    chk_i.set_step("bad_addr");
    axi_read(32'h10, data, resp);
    chk_i.compare_value("bad_addr rresp", 32'(AXIL_SLVERR), 32'(resp));
    chk_i.compare_value("bad_addr rdata", 32'h0, data);
    axi_write(32'h10, 32'h1, 4'hf, resp);
    chk_i.compare_value("bad_addr bresp", 32'(AXIL_SLVERR), 32'(resp));
    $display("errors: value %0d, period %0d, pulse %0d, other %0d",
             chk_i.value_errs, chk_i.period_errs, chk_i.pulse_errs, chk_i.other_errs);
    if (chk_i.value_errs + chk_i.period_errs + chk_i.pulse_errs + chk_i.other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // whole run bounded by table length times the step limit
  initial begin
    #((N_ORDER + 2) * (STEP_LIMIT + 200) * 10);
    $display("watchdog expired before the tests completed");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/clk_pkg.sv
design/axil_pkg.sv
design/cdc_sync.sv
design/clk_fail_monitor.sv
design/sys_clk_switch.sv
design/clk_ctrl_regs.sv
design/clk_ctrl_top.sv
sim/clk_ctrl_checker.sv
sim/clk_ctrl_props.sv
sim/clk_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clock control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module clk_ctrl_tb \
  -o clk_ctrl_sim > build.log 2>&1 \
  && ./obj_dir/clk_ctrl_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^\*\* PASS \*\*$' sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
